//--- common/ifetch_params.svh
`ifndef IFETCH_PARAMS_SVH
`define IFETCH_PARAMS_SVH

// address and instruction widths
`define IFETCH_ADDR_W 32
`define IFETCH_INSTR_W 32

// pc after reset and the step between sequential fetches
`define IFETCH_RESET_PC 32'h0000_0000
`define IFETCH_PC_STEP 32'd4

// direct-mapped geometry with one word per line
`define ICACHE_LINES 16
`define ICACHE_INDEX_W 4
`define ICACHE_TAG_W 12

// tag is addr[17:6], index is addr[5:2], byte offset addr[1:0]
`define ICACHE_INDEX_LSB 2
`define ICACHE_TAG_LSB 6

// hit and miss counter width
`define ICACHE_CNT_W 32

// queue depth doubles as the initial credit count
`define FQ_DEPTH 4
`define FQ_PTR_W 2

// wide enough to hold FQ_DEPTH itself
`define FQ_CNT_W 3

`endif

//--- common/ifetch_pkg.sv
`include "ifetch_params.svh"

package ifetch_pkg;

    typedef logic [`IFETCH_ADDR_W-1:0]  addr_t;
    typedef logic [`IFETCH_INSTR_W-1:0] instr_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    // queue occupancy, credits and flush counts
    typedef logic [`FQ_CNT_W-1:0] fq_count_t;

    typedef logic [`ICACHE_CNT_W-1:0] perf_count_t;

    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    // cache response, queue entry and decode output
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_resp_t;

    // always word aligned
    typedef struct packed {
        addr_t addr;
    } mem_req_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        ALLOCATE,
        RESPOND
    } icache_state_t;

endpackage

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "ifetch_params.svh"

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect_valid,
    input  ifetch_pkg::addr_t       redirect_pc,
    input  logic                    req_ready,
    input  logic                    resp_valid,
    input  ifetch_pkg::fetch_resp_t resp,
    input  logic                    credit_return,
    input  ifetch_pkg::fq_count_t   flush_count,
    output logic                    req_valid,
    output ifetch_pkg::fetch_req_t  req,
    output logic                    push,
    output ifetch_pkg::fetch_resp_t push_data
);

    ifetch_pkg::addr_t     pc;
    ifetch_pkg::fq_count_t credits;
    logic                  outstanding;
    logic                  stale;
    logic                  req_fire;
    logic                  drop;

    // a response from before a redirect, or landing with one, is thrown away
    assign drop      = resp_valid && (stale || redirect_valid);
    assign push      = resp_valid && !drop;
    assign push_data = resp;

    // one request in flight and only against a promised queue slot
    assign req_valid = !rst && !outstanding && (credits != '0) && !redirect_valid;
    assign req.addr  = pc;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= `IFETCH_RESET_PC;
        end
        else if (redirect_valid)
        begin
            pc <= redirect_pc;
        end
        else if (push)
        begin
            pc <= pc + `IFETCH_PC_STEP;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outstanding <= 1'b0;
            stale       <= 1'b0;
        end
        else
        begin
            if (req_fire)
                outstanding <= 1'b1;
            else if (resp_valid)
                outstanding <= 1'b0;

            if (resp_valid)
                stale <= 1'b0;
            else if (redirect_valid && outstanding)
                stale <= 1'b1;
        end
    end

    // credits come back from pops, flushes and dropped responses
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            credits <= ifetch_pkg::fq_count_t'(`FQ_DEPTH);
        end
        else
        begin
            credits <= credits + ifetch_pkg::fq_count_t'(credit_return)
                       + ifetch_pkg::fq_count_t'(drop) + flush_count
                       - ifetch_pkg::fq_count_t'(req_fire);
        end
    end

endmodule

//--- icache/icache.sv
`timescale 1ns/1ps
`include "ifetch_params.svh"

module icache (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  ifetch_pkg::fetch_req_t  req,
    input  logic                    mem_req_ready,
    input  logic                    mem_resp_valid,
    input  ifetch_pkg::instr_t      mem_resp_data,
    output logic                    req_ready,
    output logic                    resp_valid,
    output ifetch_pkg::fetch_resp_t resp,
    output logic                    mem_req_valid,
    output ifetch_pkg::mem_req_t    mem_req,
    output ifetch_pkg::perf_count_t hit_count,
    output ifetch_pkg::perf_count_t miss_count
);

    ifetch_pkg::icache_state_t state;
    ifetch_pkg::icache_state_t state_next;
    ifetch_pkg::addr_t         req_addr;
    ifetch_pkg::tag_t          req_tag;
    ifetch_pkg::index_t        req_index;
    ifetch_pkg::tag_t          tag_mem  [`ICACHE_LINES];
    ifetch_pkg::instr_t        data_mem [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]  line_valid;
    logic                      hit;
    logic                      mem_sent;
    logic                      fill;

    assign req_tag   = req_addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
    assign req_index = req_addr[`ICACHE_INDEX_LSB +: `ICACHE_INDEX_W];
    assign hit       = line_valid[req_index] && (tag_mem[req_index] == req_tag);

    // refill word arrives after the memory request was taken
    assign fill = (state == ifetch_pkg::ALLOCATE) && mem_sent && mem_resp_valid;

    always_comb
    begin
        state_next = state;
        case (state)
            ifetch_pkg::IDLE:
                if (req_valid)
                    state_next = ifetch_pkg::COMPARE;
            ifetch_pkg::COMPARE:
                state_next = hit ? ifetch_pkg::IDLE : ifetch_pkg::ALLOCATE;
            ifetch_pkg::ALLOCATE:
                if (fill)
                    state_next = ifetch_pkg::RESPOND;
            ifetch_pkg::RESPOND:
                state_next = ifetch_pkg::IDLE;
            default:
                state_next = ifetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= ifetch_pkg::IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            req_addr <= req.addr;
    end

    // cleared on every exit from ALLOCATE
    always_ff @(posedge clk)
    begin
        if (rst)
            mem_sent <= 1'b0;
        else if (state != ifetch_pkg::ALLOCATE)
            mem_sent <= 1'b0;
        else if (mem_req_valid && mem_req_ready)
            mem_sent <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            tag_mem[req_index]  <= req_tag;
            data_mem[req_index] <= mem_resp_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            line_valid <= '0;
        else if (fill)
            line_valid[req_index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_count  <= '0;
            miss_count <= '0;
        end
        else if (state == ifetch_pkg::COMPARE)
        begin
            if (hit)
                hit_count <= hit_count + 1'b1;
            else
                miss_count <= miss_count + 1'b1;
        end
    end

    assign req_ready  = (state == ifetch_pkg::IDLE);
    assign resp_valid = ((state == ifetch_pkg::COMPARE) && hit)
                        || (state == ifetch_pkg::RESPOND);
    assign resp.pc    = req_addr;
    assign resp.instr = data_mem[req_index];

    assign mem_req_valid = (state == ifetch_pkg::ALLOCATE) && !mem_sent;
    assign mem_req.addr  = {req_addr[`IFETCH_ADDR_W-1:`ICACHE_INDEX_LSB],
                            {`ICACHE_INDEX_LSB{1'b0}}};

endmodule

//--- verilog/fetch_queue.sv
`timescale 1ns/1ps
`include "ifetch_params.svh"

module fetch_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  ifetch_pkg::fetch_resp_t push_data,
    input  logic                    flush,
    input  logic                    dec_ready,
    output logic                    dec_valid,
    output ifetch_pkg::fetch_resp_t dec_data,
    output logic                    credit_return,
    output ifetch_pkg::fq_count_t   flush_count
);

    ifetch_pkg::fetch_resp_t entries [`FQ_DEPTH];
    logic [`FQ_PTR_W-1:0]    wr_ptr;
    logic [`FQ_PTR_W-1:0]    rd_ptr;
    ifetch_pkg::fq_count_t   count;
    logic                    pop;
    logic                    wr_en;

    assign dec_valid = (count != '0);
    assign dec_data  = entries[rd_ptr];
    assign pop       = dec_valid && dec_ready;
    assign wr_en     = push && !flush;

    assign credit_return = pop;

    // an entry popped in the flush cycle already returns through credit_return
    assign flush_count = flush ? (count - ifetch_pkg::fq_count_t'(pop)) : '0;

    always_ff @(posedge clk)
    begin
        if (wr_en)
            entries[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + ifetch_pkg::fq_count_t'(wr_en)
                     - ifetch_pkg::fq_count_t'(pop);
        end
    end

endmodule

//--- verilog/ifetch_top.sv
`timescale 1ns/1ps

module ifetch_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect_valid,
    input  ifetch_pkg::addr_t       redirect_pc,
    output logic                    mem_req_valid,
    output ifetch_pkg::mem_req_t    mem_req,
    input  logic                    mem_req_ready,
    input  logic                    mem_resp_valid,
    input  ifetch_pkg::instr_t      mem_resp_data,
    output logic                    dec_valid,
    output ifetch_pkg::fetch_resp_t dec_data,
    input  logic                    dec_ready,
    output ifetch_pkg::perf_count_t hit_count,
    output ifetch_pkg::perf_count_t miss_count
);

    logic                    req_valid;
    logic                    req_ready;
    ifetch_pkg::fetch_req_t  req;
    logic                    resp_valid;
    ifetch_pkg::fetch_resp_t resp;
    logic                    push;
    ifetch_pkg::fetch_resp_t push_data;
    logic                    credit_return;
    ifetch_pkg::fq_count_t   flush_count;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .credit_return  (credit_return),
        .flush_count    (flush_count),
        .req_valid      (req_valid),
        .req            (req),
        .push           (push),
        .push_data      (push_data)
    );

    icache u_icache (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .hit_count      (hit_count),
        .miss_count     (miss_count)
    );

    // a redirect also empties the queue
    fetch_queue u_fetch_queue (
        .clk            (clk),
        .rst            (rst),
        .push           (push),
        .push_data      (push_data),
        .flush          (redirect_valid),
        .dec_ready      (dec_ready),
        .dec_valid      (dec_valid),
        .dec_data       (dec_data),
        .credit_return  (credit_return),
        .flush_count    (flush_count)
    );

endmodule

//--- tb/ifetch_assertions.sv
`timescale 1ns/1ps

module ifetch_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    redirect_valid,
    input logic                    req_valid,
    input logic                    req_ready,
    input ifetch_pkg::fetch_req_t  req,
    input logic                    resp_valid,
    input logic                    push,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input ifetch_pkg::mem_req_t    mem_req,
    input logic                    dec_valid,
    input logic                    dec_ready
);

    logic                  pending;
    ifetch_pkg::fq_count_t occupancy;
    int                    assert_errors = 0;

    always_ff @(posedge clk)
    begin
        if (rst)
            pending <= 1'b0;
        else if (req_valid && req_ready)
            pending <= 1'b1;
        else if (resp_valid)
            pending <= 1'b0;
    end

    // shadow of the queue fill level
    always_ff @(posedge clk)
    begin
        if (rst || redirect_valid)
            occupancy <= '0;
        else
            occupancy <= occupancy + ifetch_pkg::fq_count_t'(push)
                         - ifetch_pkg::fq_count_t'(dec_valid && dec_ready);
    end

    req_stable: assert property (@(posedge clk) disable iff (rst || redirect_valid)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
    else
    begin
        assert_errors++;
        $error("req changed while waiting for req_ready");
    end

    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
    else
    begin
        assert_errors++;
        $error("mem_req dropped or changed before acceptance");
    end

    no_empty_pop: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && dec_ready) |-> (occupancy != '0))
    else
    begin
        assert_errors++;
        $error("pop from an empty fetch queue");
    end

    resp_has_req: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> pending)
    else
    begin
        assert_errors++;
        $error("cache response without an outstanding request");
    end

endmodule

bind ifetch_top ifetch_assertions u_ifetch_assertions (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req            (req),
    .resp_valid     (resp_valid),
    .push           (push),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready)
);

//--- tb/tb_ifetch.sv
`timescale 1ns/1ps

module tb_ifetch;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    redirect_valid;
    ifetch_pkg::addr_t       redirect_pc;
    logic                    mem_req_valid;
    ifetch_pkg::mem_req_t    mem_req;
    logic                    mem_req_ready = 1'b0;
    logic                    mem_resp_valid = 1'b0;
    ifetch_pkg::instr_t      mem_resp_data = '0;
    logic                    dec_valid;
    ifetch_pkg::fetch_resp_t dec_data;
    logic                    dec_ready;
    ifetch_pkg::perf_count_t hit_count;
    ifetch_pkg::perf_count_t miss_count;

    logic [31:0] golden [0:255];
    logic [31:0] mem_image [0:63];
    logic [31:0] ev_kind [0:15];
    logic [31:0] ev_pops [0:15];
    logic [31:0] ev_arg [0:15];
    logic [31:0] exp_pc [0:63];
    logic [31:0] exp_instr [0:63];
    logic [31:0] exp_hits;
    logic [31:0] exp_misses;
    int          n_mem;
    int          n_ev;
    int          n_exp;
    int          pop_idx = 0;
    int          stream_errors = 0;
    int          counter_errors = 0;
    int          cycle_count = 0;
    int          timeout_limit = 100000;
    int          seed = 6539;
    int          rnd;
    logic        mem_busy = 1'b0;
    int          mem_wait = 0;
    ifetch_pkg::addr_t mem_addr = '0;

    ifetch_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .dec_valid      (dec_valid),
        .dec_data       (dec_data),
        .dec_ready      (dec_ready),
        .hit_count      (hit_count),
        .miss_count     (miss_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit)
        begin
            $display("timeout after %0d cycles, the fetch stream did not complete", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // words past the image get a pattern of the full address
    function automatic logic [31:0] mem_word(input ifetch_pkg::addr_t addr);
        if (int'(addr >> 2) < n_mem)
            return mem_image[addr >> 2];
        else
            return addr ^ 32'h5a5a_a5a5;
    endfunction

    // memory model with one request at a time and random ready and latency
    always @(negedge clk)
    begin
        if (rst)
        begin
            mem_req_ready  = 1'b0;
            mem_resp_valid = 1'b0;
            mem_busy       = 1'b0;
        end
        else
        begin
            mem_resp_valid = 1'b0;
            if (mem_busy)
            begin
                if (mem_wait == 0)
                begin
                    mem_resp_valid = 1'b1;
                    mem_resp_data  = mem_word(mem_addr);
                    mem_busy       = 1'b0;
                end
                else
                begin
                    mem_wait = mem_wait - 1;
                end
            end
            rnd = $random(seed);
            mem_req_ready = !mem_busy && ((rnd & 3) != 0);
            if (!mem_busy && mem_req_valid && mem_req_ready)
            begin
                rnd      = $random(seed);
                mem_busy = 1'b1;
                mem_addr = mem_req.addr;
                mem_wait = 1 + (rnd & 3);
            end
        end
    end

    task automatic load_golden();
        int pos;
        $readmemh("tb/ifetch_golden.txt", golden);
        pos   = 0;
        n_mem = int'(golden[pos]);
        pos++;
        for (int i = 0; i < n_mem; i++)
        begin
            mem_image[i] = golden[pos];
            pos++;
        end
        n_ev = int'(golden[pos]);
        pos++;
        for (int i = 0; i < n_ev; i++)
        begin
            ev_kind[i] = golden[pos];
            ev_pops[i] = golden[pos + 1];
            ev_arg[i]  = golden[pos + 2];
            pos += 3;
        end
        n_exp = int'(golden[pos]);
        pos++;
        for (int i = 0; i < n_exp; i++)
        begin
            exp_pc[i]    = golden[pos];
            exp_instr[i] = golden[pos + 1];
            pos += 2;
        end
        exp_hits   = golden[pos];
        exp_misses = golden[pos + 1];
    endtask

    task automatic check_pop();
        assert (dec_data.pc == exp_pc[pop_idx])
        else
        begin
            stream_errors++;
            $display("[ERROR] %0t dec_data.pc got %h expected %h",
                     $time, dec_data.pc, exp_pc[pop_idx]);
        end
        assert (dec_data.instr == exp_instr[pop_idx])
        else
        begin
            stream_errors++;
            $display("[ERROR] %0t dec_data.instr got %h expected %h",
                     $time, dec_data.instr, exp_instr[pop_idx]);
        end
    endtask

    // pops until the given total and then holds decode off
    task automatic run_to_pops(input int limit);
        while (pop_idx < limit)
        begin
            @(negedge clk);
            dec_ready = 1'b1;
            if (dec_valid)
            begin
                check_pop();
                pop_idx++;
            end
        end
        @(negedge clk);
        dec_ready = 1'b0;
    endtask

    // fetch is idle once every credit sits in the queue
    task automatic wait_fetch_idle();
        while ((dut0.u_fetch_unit.credits != '0) || dut0.u_fetch_unit.outstanding)
            @(negedge clk);
    endtask

    task automatic apply_redirect(input ifetch_pkg::addr_t target);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic check_counters();
        assert (hit_count == exp_hits)
        else
        begin
            counter_errors++;
            $display("[ERROR] %0t hit_count got %0d expected %0d", $time, hit_count, exp_hits);
        end
        assert (miss_count == exp_misses)
        else
        begin
            counter_errors++;
            $display("[ERROR] %0t miss_count got %0d expected %0d",
                     $time, miss_count, exp_misses);
        end
    endtask

    initial
    begin
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dec_ready      = 1'b0;
        load_golden();
        timeout_limit = 40 * n_exp + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int e = 0; e < n_ev; e++)
        begin
            run_to_pops(int'(ev_pops[e]));
            if (ev_kind[e] == 32'd1)
            begin
                wait_fetch_idle();
                apply_redirect(ev_arg[e]);
            end
            else
            begin
                repeat (int'(ev_arg[e])) @(negedge clk);
            end
        end
        run_to_pops(n_exp);
        wait_fetch_idle();
        check_counters();

        $display("errors: stream %0d, counters %0d, assertions %0d",
                 stream_errors, counter_errors, dut0.u_ifetch_assertions.assert_errors);
        if (stream_errors + counter_errors + dut0.u_ifetch_assertions.assert_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- tb/ifetch_golden.txt
// memory word count, then the image from address 0, four words per line
18
00000013 00100093 00200113 00308193
00410213 00518293 00620313 00728393
00830413 00938493 00a40513 00b48593
00c50613 00d58693 00e60713 00f68793
1234a0b7 2345b137 3456c1b7 4567d237
5678e2b7 6789f337 789a03b7 89ab1437
// event count, then kind (1 redirect, 2 decode stall), pops before it, target pc or stall cycles
5
1 8  00000000
2 a  0000003c
1 e  00000040
1 10 00000000
1 12 00000040
// expected pop count, then pc and instruction of each pop
14
00000000 00000013
00000004 00100093
00000008 00200113
0000000c 00308193
00000010 00410213
00000014 00518293
00000018 00620313
0000001c 00728393
00000000 00000013
00000004 00100093
00000008 00200113
0000000c 00308193
00000010 00410213
00000014 00518293
00000040 1234a0b7
00000044 2345b137
00000000 00000013
00000004 00100093
00000040 1234a0b7
00000044 2345b137
// final hit count and miss count
0000000a 0000001e

//--- sim.f
+incdir+common
common/ifetch_pkg.sv
verilog/fetch_unit.sv
icache/icache.sv
verilog/fetch_queue.sv
verilog/ifetch_top.sv
tb/ifetch_assertions.sv
tb/tb_ifetch.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ifetch
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG) || ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
